// ==== common/gray_pkg.sv ====
package gray_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------

    localparam int CH_W = 10;
    localparam int LEN_W = 20;

    // each weight fits in seven bits, so a product needs CH_W + 7 bits.
    localparam int WGT_W = 7;
    localparam int PROD_W = CH_W + WGT_W;

    // the pipeline holds at most four pixels between reader and output.
    localparam int FLIGHT_W = 3;

    localparam logic [CH_W-1:0] CH_MAX = '1;

    // --------------------------------------------------
    // luma weights and shifts
    // --------------------------------------------------

    // fixed-point weights of roughly 0.30, 0.59 and 0.14.
    localparam logic [WGT_W-1:0] W_RED = 7'd19;
    localparam logic [WGT_W-1:0] W_GREEN = 7'd75;
    localparam logic [WGT_W-1:0] W_BLUE = 7'd37;

    localparam int SH_RED = 6;
    localparam int SH_GREEN = 7;
    localparam int SH_BLUE = 8;

    // a gray value above this is bright, so bw goes to 0.
    localparam logic [CH_W-1:0] BW_THRESHOLD = 10'd512;

    // a spread above this marks the pixel as vivid.
    localparam logic [CH_W-1:0] VIVID_THRESHOLD = 10'd256;

    // --------------------------------------------------
    // pixel types
    // --------------------------------------------------

    typedef struct packed {
        logic [CH_W-1:0] red;
        logic [CH_W-1:0] green;
        logic [CH_W-1:0] blue;
    } rgb_t;

    typedef struct packed {
        logic [CH_W-1:0] gray;
    } luma_t;

    typedef struct packed {
        logic [CH_W-1:0] spread;
    } spread_t;

    typedef struct packed {
        logic [CH_W-1:0] gray;
        logic            bw;
        logic            vivid;
    } gray_pix_t;

endpackage

// ==== hw/frame_reader.sv ====
`timescale 1ns/1ps

module frame_reader (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_start,
    input  logic [gray_pkg::LEN_W-1:0]   i_frame_len,
    output logic                         o_mem_req,
    input  logic                         i_mem_ack,
    input  gray_pkg::rgb_t               i_mem_pix,
    output gray_pkg::rgb_t               o_pix,
    output logic                         o_valid,
    input  logic                         i_ready,
    input  logic                         i_last_out,
    output logic                         o_busy
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_HANDOFF,
        S_DRAIN,
        S_WAIT_LOW
    } state_t;

    state_t                       state_r;
    logic [gray_pkg::LEN_W-1:0]   len_r;
    logic [gray_pkg::LEN_W-1:0]   cnt_r;
    logic                         req_r;
    logic                         got_ack;
    gray_pkg::rgb_t               pix_r;

    assign got_ack = (state_r == S_FETCH) && req_r && i_mem_ack;

    assign o_mem_req = req_r;
    assign o_pix = pix_r;
    assign o_valid = (state_r == S_HANDOFF);
    assign o_busy = (state_r == S_FETCH) || (state_r == S_HANDOFF) || (state_r == S_DRAIN);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= S_IDLE;
            len_r <= '0;
            cnt_r <= '0;
            req_r <= 1'b0;
        end else begin
            case (state_r)
                S_IDLE: begin
                    if (i_start) begin
                        len_r <= i_frame_len;
                        cnt_r <= '0;
                        state_r <= (i_frame_len == '0) ? S_WAIT_LOW : S_FETCH;
                    end
                end
                S_FETCH: begin
                    // a new request only goes out once memory has released ack.
                    if (got_ack) begin
                        req_r <= 1'b0;
                        cnt_r <= cnt_r + 1'b1;
                        state_r <= S_HANDOFF;
                    end else if (!req_r && !i_mem_ack) begin
                        req_r <= 1'b1;
                    end
                end
                S_HANDOFF: begin
                    if (i_ready) begin
                        state_r <= (cnt_r == len_r) ? S_DRAIN : S_FETCH;
                    end
                end
                S_DRAIN: begin
                    if (i_last_out) begin
                        state_r <= S_WAIT_LOW;
                    end
                end
                S_WAIT_LOW: begin
                    if (!i_start) begin
                        state_r <= S_IDLE;
                    end
                end
                default: state_r <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (got_ack) begin
            pix_r <= i_mem_pix;
        end
    end

    // the previous ack must have been low when req comes up again.
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_mem_req) |-> !$past(i_mem_ack));

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_pix)));

endmodule

// ==== hw/stage_skid.sv ====
`timescale 1ns/1ps

module stage_skid #(
    parameter type T = logic [7:0]
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  T     i_data,
    input  logic i_valid,
    output logic o_ready,
    output T     o_data,
    output logic o_valid,
    input  logic i_ready
);

    T           mem_r [2];
    logic [1:0] count_r;
    logic       wr_ptr_r;
    logic       rd_ptr_r;
    logic       bypass;
    logic       push;
    logic       pop;

    // ready comes from the fill level alone, so the downstream ready
    // never reaches the upstream stage in the same cycle.
    assign o_ready = (count_r != 2'd2);
    assign o_valid = (count_r != 2'd0) || i_valid;
    assign o_data = (count_r != 2'd0) ? mem_r[rd_ptr_r] : i_data;

    // an empty buffer passes the input straight on when it can.
    assign bypass = (count_r == 2'd0) && i_valid && i_ready;
    assign push = i_valid && o_ready && !bypass;
    assign pop = (count_r != 2'd0) && i_ready;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count_r <= 2'd0;
            wr_ptr_r <= 1'b0;
            rd_ptr_r <= 1'b0;
        end else begin
            if (push && !pop) begin
                count_r <= count_r + 2'd1;
            end else if (pop && !push) begin
                count_r <= count_r - 2'd1;
            end
            if (push) begin
                wr_ptr_r <= ~wr_ptr_r;
            end
            if (pop) begin
                rd_ptr_r <= ~rd_ptr_r;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem_r[wr_ptr_r] <= i_data;
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        count_r != 2'd3);

endmodule

// ==== convert/luma_weigher.sv ====
`timescale 1ns/1ps

module luma_weigher (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  gray_pkg::rgb_t  i_pix,
    input  logic            i_valid,
    output logic            o_ready,
    output gray_pkg::luma_t o_luma,
    output logic            o_valid,
    input  logic            i_ready
);

    logic [gray_pkg::PROD_W-1:0] red_prod;
    logic [gray_pkg::PROD_W-1:0] green_prod;
    logic [gray_pkg::PROD_W-1:0] blue_prod;
    logic [gray_pkg::PROD_W-1:0] sum;
    logic [gray_pkg::CH_W-1:0]   gray_sat;
    logic                        take;
    logic                        valid_r;
    gray_pkg::luma_t             luma_r;

    // --------------------------------------------------
    // weighted sum
    // --------------------------------------------------

    assign red_prod = i_pix.red * gray_pkg::W_RED;
    assign green_prod = i_pix.green * gray_pkg::W_GREEN;
    assign blue_prod = i_pix.blue * gray_pkg::W_BLUE;

    assign sum = (red_prod >> gray_pkg::SH_RED)
               + (green_prod >> gray_pkg::SH_GREEN)
               + (blue_prod >> gray_pkg::SH_BLUE);

    // full-scale inputs sum to a little over 1023, so clip there.
    assign gray_sat = (sum > gray_pkg::PROD_W'(gray_pkg::CH_MAX)) ?
                      gray_pkg::CH_MAX : sum[gray_pkg::CH_W-1:0];

    // --------------------------------------------------
    // output register
    // --------------------------------------------------

    assign o_ready = !valid_r || i_ready;
    assign take = i_valid && o_ready;
    assign o_valid = valid_r;
    assign o_luma = luma_r;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_r <= 1'b0;
        end else if (take) begin
            valid_r <= 1'b1;
        end else if (i_ready) begin
            valid_r <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            luma_r.gray <= gray_sat;
        end
    end

endmodule

// ==== convert/chroma_spread.sv ====
`timescale 1ns/1ps

module chroma_spread (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  gray_pkg::rgb_t    i_pix,
    input  logic              i_valid,
    output logic              o_ready,
    output gray_pkg::spread_t o_spread,
    output logic              o_valid,
    input  logic              i_ready
);

    logic [gray_pkg::CH_W-1:0] max_rg;
    logic [gray_pkg::CH_W-1:0] min_rg;
    logic [gray_pkg::CH_W-1:0] ch_max;
    logic [gray_pkg::CH_W-1:0] ch_min;
    logic                      take;
    logic                      valid_r;
    gray_pkg::spread_t         spread_r;

    // largest and smallest of the three channels.
    assign max_rg = (i_pix.red > i_pix.green) ? i_pix.red : i_pix.green;
    assign min_rg = (i_pix.red > i_pix.green) ? i_pix.green : i_pix.red;
    assign ch_max = (max_rg > i_pix.blue) ? max_rg : i_pix.blue;
    assign ch_min = (min_rg < i_pix.blue) ? min_rg : i_pix.blue;

    assign o_ready = !valid_r || i_ready;
    assign take = i_valid && o_ready;
    assign o_valid = valid_r;
    assign o_spread = spread_r;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_r <= 1'b0;
        end else if (take) begin
            valid_r <= 1'b1;
        end else if (i_ready) begin
            valid_r <= 1'b0;
        end
    end

    // max is never below min, so the difference cannot wrap.
    always_ff @(posedge i_clk) begin
        if (take) begin
            spread_r.spread <= ch_max - ch_min;
        end
    end

endmodule

// ==== convert/pixel_classifier.sv ====
`timescale 1ns/1ps

module pixel_classifier (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  gray_pkg::luma_t     i_luma,
    input  logic                i_luma_valid,
    output logic                o_luma_ready,
    input  gray_pkg::spread_t   i_spread,
    input  logic                i_spread_valid,
    output logic                o_spread_ready,
    output gray_pkg::gray_pix_t o_pix,
    output logic                o_valid,
    input  logic                i_ready
);

    logic                take;
    logic                valid_r;
    gray_pkg::gray_pix_t pix_r;

    // both inputs are consumed together, and only when the output can move.
    assign take = i_luma_valid && i_spread_valid && (!valid_r || i_ready);
    assign o_luma_ready = take;
    assign o_spread_ready = take;

    assign o_valid = valid_r;
    assign o_pix = pix_r;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_r <= 1'b0;
        end else if (take) begin
            valid_r <= 1'b1;
        end else if (i_ready) begin
            valid_r <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            pix_r.gray <= i_luma.gray;
            // bw is 1 for dark pixels.
            pix_r.bw <= (i_luma.gray > gray_pkg::BW_THRESHOLD) ? 1'b0 : 1'b1;
            pix_r.vivid <= (i_spread.spread > gray_pkg::VIVID_THRESHOLD) ? 1'b1 : 1'b0;
        end
    end

    // the luma and chroma streams run in lockstep, so a lone valid means they
    // have shifted apart.
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_luma_valid == i_spread_valid);

endmodule

// ==== hw/grayscale_top.sv ====
`timescale 1ns/1ps

module grayscale_top (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_start,
    input  logic [gray_pkg::LEN_W-1:0] i_frame_len,
    output logic                       o_mem_req,
    input  logic                       i_mem_ack,
    input  gray_pkg::rgb_t             i_mem_pix,
    output gray_pkg::gray_pix_t        o_pix,
    output logic                       o_valid,
    input  logic                       i_ready,
    output logic                       o_busy
);

    gray_pkg::rgb_t                rd_pix;
    logic                          rd_valid;
    logic                          luma_in_ready;
    logic                          chroma_in_ready;
    logic                          path_ready;
    logic                          path_valid;
    gray_pkg::luma_t               luma_d;
    logic                          luma_valid;
    logic                          luma_ready;
    gray_pkg::spread_t             spread_d;
    logic                          spread_valid;
    logic                          spread_ready;
    gray_pkg::luma_t               luma_q;
    logic                          luma_q_valid;
    logic                          luma_q_ready;
    gray_pkg::spread_t             spread_q;
    logic                          spread_q_valid;
    logic                          spread_q_ready;
    logic                          out_fire;
    logic                          last_out;
    logic [gray_pkg::FLIGHT_W-1:0] flight_r;

    // --------------------------------------------------
    // path handshake and frame end detection
    // --------------------------------------------------

    assign path_ready = luma_in_ready && chroma_in_ready;
    assign path_valid = rd_valid && path_ready;
    assign out_fire = o_valid && i_ready;

    // the reader only listens to this while draining, when nothing new enters.
    assign last_out = out_fire && (flight_r == gray_pkg::FLIGHT_W'(1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            flight_r <= '0;
        end else if (path_valid && !out_fire) begin
            flight_r <= flight_r + 1'b1;
        end else if (out_fire && !path_valid) begin
            flight_r <= flight_r - 1'b1;
        end
    end

    frame_reader u_reader (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(i_start), .i_frame_len(i_frame_len),
        .o_mem_req(o_mem_req), .i_mem_ack(i_mem_ack), .i_mem_pix(i_mem_pix),
        .o_pix(rd_pix), .o_valid(rd_valid), .i_ready(path_ready),
        .i_last_out(last_out), .o_busy(o_busy)
    );

    luma_weigher u_luma (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_pix(rd_pix), .i_valid(path_valid),
        .o_ready(luma_in_ready), .o_luma(luma_d), .o_valid(luma_valid), .i_ready(luma_ready)
    );

    chroma_spread u_chroma (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_pix(rd_pix), .i_valid(path_valid),
        .o_ready(chroma_in_ready), .o_spread(spread_d), .o_valid(spread_valid),
        .i_ready(spread_ready)
    );

    stage_skid #(.T(gray_pkg::luma_t)) u_luma_skid (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_data(luma_d), .i_valid(luma_valid),
        .o_ready(luma_ready), .o_data(luma_q), .o_valid(luma_q_valid), .i_ready(luma_q_ready)
    );

    stage_skid #(.T(gray_pkg::spread_t)) u_spread_skid (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_data(spread_d), .i_valid(spread_valid),
        .o_ready(spread_ready), .o_data(spread_q), .o_valid(spread_q_valid),
        .i_ready(spread_q_ready)
    );

    pixel_classifier u_classifier (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_luma(luma_q), .i_luma_valid(luma_q_valid), .o_luma_ready(luma_q_ready),
        .i_spread(spread_q), .i_spread_valid(spread_q_valid), .o_spread_ready(spread_q_ready),
        .o_pix(o_pix), .o_valid(o_valid), .i_ready(i_ready)
    );

endmodule

// ==== tests/tb_gray_model.svh ====
`ifndef TB_GRAY_MODEL_SVH
`define TB_GRAY_MODEL_SVH

// --------------------------------------------------
// reference model
// --------------------------------------------------

// expected output pixels, oldest first.
gray_pkg::gray_pix_t exp_q[$];

// weights 19/64, 75/128 and 37/256, each term truncated before the sum.
function automatic logic [9:0] weighted_gray(input gray_pkg::rgb_t pix);
    int total;
    total = ((int'(pix.red) * 19) >> 6)
          + ((int'(pix.green) * 75) >> 7)
          + ((int'(pix.blue) * 37) >> 8);
    if (total > 1023) begin
        total = 1023;
    end
    return 10'(total);
endfunction

function automatic int channel_spread(input gray_pkg::rgb_t pix);
    int hi;
    int lo;
    hi = int'(pix.red);
    lo = int'(pix.red);
    if (int'(pix.green) > hi) begin
        hi = int'(pix.green);
    end
    if (int'(pix.green) < lo) begin
        lo = int'(pix.green);
    end
    if (int'(pix.blue) > hi) begin
        hi = int'(pix.blue);
    end
    if (int'(pix.blue) < lo) begin
        lo = int'(pix.blue);
    end
    return hi - lo;
endfunction

function automatic gray_pkg::gray_pix_t expected_pixel(input gray_pkg::rgb_t pix);
    gray_pkg::gray_pix_t want;
    want.gray = weighted_gray(pix);
    // a gray value up to 512 still counts as dark.
    want.bw = (int'(want.gray) <= 512);
    want.vivid = (channel_spread(pix) > 256);
    return want;
endfunction

function automatic void queue_expected(input gray_pkg::rgb_t pix);
    exp_q.push_back(expected_pixel(pix));
endfunction

`endif

// ==== tests/tb_grayscale.sv ====
`timescale 1ns/1ps

module tb_grayscale;

    localparam int LEN_FIRST = 40;
    localparam int LEN_SECOND = 48;
    // fetch, ack delay and stalls together stay well below this per pixel.
    localparam int CYC_PER_PIX = 24;
    localparam int CYCLE_LIMIT = (LEN_FIRST + LEN_SECOND) * CYC_PER_PIX + 300;

    logic                       clk;
    logic                       rst_n;
    logic                       start;
    logic [gray_pkg::LEN_W-1:0] frame_len;
    logic                       mem_req;
    logic                       mem_ack;
    gray_pkg::rgb_t             mem_pix;
    gray_pkg::gray_pix_t        out_pix;
    logic                       out_valid;
    logic                       out_ready;
    logic                       busy;

    gray_pkg::rgb_t             src_q[$];
    gray_pkg::gray_pix_t        held_pix;
    logic                       stalled;
    logic                       req_prev;
    logic                       frame_active;
    int                         ack_delay;
    int                         stall_pct;
    int                         out_count;
    int                         cur_len;
    int                         cycles;
    int                         err_value;
    int                         err_proto;

    `include "tb_gray_model.svh"

    grayscale_top uut (
        .i_clk(clk),
        .i_rst_n(rst_n),
        .i_start(start),
        .i_frame_len(frame_len),
        .o_mem_req(mem_req),
        .i_mem_ack(mem_ack),
        .i_mem_pix(mem_pix),
        .o_pix(out_pix),
        .o_valid(out_valid),
        .i_ready(out_ready),
        .o_busy(busy)
    );

    function automatic gray_pkg::rgb_t make_pixel(input int r, input int g, input int b);
        gray_pkg::rgb_t pix;
        pix.red = 10'(r);
        pix.green = 10'(g);
        pix.blue = 10'(b);
        return pix;
    endfunction

    function automatic gray_pkg::rgb_t random_pixel();
        return make_pixel($urandom_range(0, 1023), $urandom_range(0, 1023),
                          $urandom_range(0, 1023));
    endfunction

    task automatic report_mismatch(input string name, input int want, input int got);
        $display("[ERROR] %s: expected %0d actual %0d", name, want, got);
        err_value++;
    endtask

    task automatic check_output(input gray_pkg::gray_pix_t got);
        gray_pkg::gray_pix_t want;
        if (exp_q.size() == 0) begin
            $display("an output pixel arrived with no pixel pending");
            err_value++;
        end else begin
            want = exp_q.pop_front();
            assert (got.gray == want.gray) else
                report_mismatch($sformatf("gray value, pixel %0d", out_count),
                                want.gray, got.gray);
            assert (got.bw == want.bw) else
                report_mismatch($sformatf("bw bit, pixel %0d", out_count), want.bw, got.bw);
            assert (got.vivid == want.vivid) else
                report_mismatch($sformatf("vivid bit, pixel %0d", out_count),
                                want.vivid, got.vivid);
        end
        out_count++;
    endtask

    task automatic load_pixels(input int len, input bit directed);
        if (directed) begin
            // gray 512 and 513 around the bw threshold, then spread 256 and 257.
            src_q.push_back(make_pixel(0, 874, 0));
            src_q.push_back(make_pixel(0, 876, 0));
            src_q.push_back(make_pixel(256, 0, 0));
            src_q.push_back(make_pixel(257, 0, 0));
            src_q.push_back(make_pixel(1023, 1023, 1023));
            src_q.push_back(make_pixel(0, 0, 0));
        end
        while (src_q.size() < len) begin
            src_q.push_back(random_pixel());
        end
    endtask

    task automatic run_frame(input int len);
        out_count = 0;
        cur_len = len;
        frame_len = gray_pkg::LEN_W'(len);
        start = 1'b1;
        @(negedge clk);
        frame_active = 1'b1;
        while (busy) begin
            @(negedge clk);
        end
        frame_active = 1'b0;
        assert (out_count == len) else report_mismatch("frame length", len, out_count);
        assert (exp_q.size() == 0) else begin
            $display("pixels were fetched but never came out");
            err_proto++;
        end
    endtask

    // --------------------------------------------------
    // memory responder
    // --------------------------------------------------

    always @(negedge clk) begin
        if (rst_n) begin
            assert (!(mem_req && !req_prev && mem_ack)) else begin
                $display("request raised while ack was still high");
                err_proto++;
            end
            if (mem_req && !mem_ack) begin
                if (!req_prev) begin
                    assert (src_q.size() > 0) else begin
                        $display("request issued beyond the frame length");
                        err_proto++;
                    end
                end
                if (src_q.size() > 0 && ack_delay > 0) begin
                    ack_delay--;
                end else if (src_q.size() > 0) begin
                    mem_pix = src_q.pop_front();
                    queue_expected(mem_pix);
                    mem_ack = 1'b1;
                    // ack stays up a few cycles after req falls.
                    ack_delay = $urandom_range(0, 3);
                end
            end else if (mem_ack && !mem_req) begin
                if (ack_delay > 0) begin
                    ack_delay--;
                end else begin
                    mem_ack = 1'b0;
                    mem_pix = random_pixel();
                    ack_delay = $urandom_range(0, 3);
                end
            end
            req_prev = mem_req;
        end
    end

    // --------------------------------------------------
    // output side
    // --------------------------------------------------

    always @(negedge clk) begin
        if (rst_n) begin
            if (stalled) begin
                assert (out_valid && out_pix == held_pix) else
                    report_mismatch("stall hold", int'(held_pix), int'(out_pix));
            end
            if (frame_active && out_count < cur_len) begin
                assert (busy) else begin
                    $display("busy dropped before the last pixel left");
                    err_proto++;
                end
            end
            out_ready = ($urandom_range(0, 99) >= stall_pct);
            stalled = out_valid && !out_ready;
            held_pix = out_pix;
            // the transfer itself happens on the next rising edge.
            if (out_valid && out_ready) begin
                check_output(out_pix);
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not end within %0d cycles", cycles);
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h14f0));
        rst_n = 1'b0;
        start = 1'b0;
        frame_len = '0;
        mem_ack = 1'b0;
        mem_pix = '0;
        out_ready = 1'b0;
        held_pix = '0;
        stalled = 1'b0;
        req_prev = 1'b0;
        frame_active = 1'b0;
        ack_delay = 0;
        stall_pct = 30;
        out_count = 0;
        cur_len = 0;
        err_value = 0;
        err_proto = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        assert (!mem_req && !out_valid && !busy) else begin
            $display("outputs were not idle after reset");
            err_proto++;
        end

        load_pixels(LEN_FIRST, 1'b1);
        run_frame(LEN_FIRST);
        // start is still high, so the reader has to stay idle.
        repeat (8) begin
            @(negedge clk);
            assert (!busy && !mem_req) else begin
                $display("a new frame began while start stayed high");
                err_proto++;
            end
        end
        start = 1'b0;
        repeat (2) @(negedge clk);

        // the output drains slower than the reader fetches, so the pipeline fills.
        stall_pct = 75;
        load_pixels(LEN_SECOND, 1'b0);
        run_frame(LEN_SECOND);
        start = 1'b0;
        repeat (4) @(negedge clk);

        $display("errors: value %0d, protocol %0d", err_value, err_proto);
        if (err_value == 0 && err_proto == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+tests
common/gray_pkg.sv
hw/frame_reader.sv
hw/stage_skid.sv
convert/luma_weigher.sv
convert/chroma_spread.sv
convert/pixel_classifier.sv
hw/grayscale_top.sv
tests/tb_grayscale.sv

// ==== Makefile ====
# Verilator simulation of the grayscale testbench.

VERILATOR ?= verilator
TOP       ?= tb_grayscale
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
